// File: hdl/align_pkg.sv
/*
 * Alignment buffer shared definitions
 * Sizes, the fetched word view and the compressed instruction check
 */
package align_pkg;

  // Address width, one fetch word
  localparam int ADDR_W = 32;

  // Three entries are needed to hold a split instruction while fetching ahead
  localparam int FIFO_DEPTH = 3;
  localparam int PTR_W      = $clog2(FIFO_DEPTH);

  // Complete instructions held in the buffer
  localparam int CNT_W = 3;

  // Fetch requests in flight at most
  localparam int MAX_OUTSTANDING = 2;

  // Two halfwords of one fetched word, upper half first
  typedef struct packed {
    logic [15:0] hi;
    logic [15:0] lo;
  } half_pair_t;

  // One fetched word, read whole or as halfwords
  typedef union packed {
    logic [31:0] word;
    half_pair_t  half;
  } fetch_word_u;

  // RVC encoding, opcode bits 1:0 other than 2'b11
  function automatic logic is_compressed(input logic [15:0] hw);
    return hw[1:0] != 2'b11;
  endfunction

endpackage

// File: hdl/fetch_req_ctrl.sv
/*
 * Fetch request control
 * Throttles word requests, tracks outstanding requests and drops
 * responses that belong to a stream abandoned by a branch
 */
module fetch_req_ctrl (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        fetch_en_i,
  input  logic                        branch_i,
  input  logic                        fetch_ready_i,
  input  logic                        resp_valid_i,
  input  logic [align_pkg::CNT_W-1:0] insn_cnt_i,
  output logic                        fetch_valid_o,
  output logic                        fetch_accept_o,
  output logic                        resp_keep_o,
  output logic                        prefetch_busy_o
);

  // Counter width covering 0..MAX_OUTSTANDING
  localparam int OCW = $clog2(align_pkg::MAX_OUTSTANDING + 1);
  localparam int CW  = align_pkg::CNT_W;

  logic [OCW-1:0] outstanding_q;
  logic [OCW-1:0] outstanding_d;
  logic [OCW-1:0] flush_q;
  logic [OCW-1:0] flush_d;
  logic           room;
  logic           need_words;

  ////////////////////
  // Request decision
  ////////////////////

  // Room for one more request on the bus
  assign room = outstanding_q < OCW'(align_pkg::MAX_OUTSTANDING);

  // Buffer running dry, or one left with nothing on the way
  assign need_words = (insn_cnt_i == CW'(0)) ||
                      ((insn_cnt_i == CW'(1)) && (outstanding_q == OCW'(0)));

  // A branch always asks for the target word
  assign fetch_valid_o  = fetch_en_i && room && (need_words || branch_i);
  assign fetch_accept_o = fetch_valid_o && fetch_ready_i;

  // Response for the current stream, nothing left to flush
  // Responses in the branch cycle belong to the old stream
  assign resp_keep_o = resp_valid_i && (flush_q == OCW'(0)) && !branch_i;

  // Anything on the bus or about to be
  assign prefetch_busy_o = (outstanding_q != OCW'(0)) || fetch_valid_o;

  ////////////////////
  // Counters
  ////////////////////

  always_comb begin
    outstanding_d = outstanding_q;
    if (fetch_accept_o && !resp_valid_i) begin
      outstanding_d = outstanding_q + OCW'(1);
    end else if (!fetch_accept_o && resp_valid_i) begin
      outstanding_d = outstanding_q - OCW'(1);
    end
  end

  // On a branch every request still in flight is stale
  // A response in the same cycle is already gone
  always_comb begin
    flush_d = flush_q;
    if (branch_i) begin
      flush_d = resp_valid_i ? outstanding_q - OCW'(1) : outstanding_q;
    end else if (resp_valid_i && (flush_q != OCW'(0))) begin
      flush_d = flush_q - OCW'(1);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding_q <= '0;
      flush_q       <= '0;
    end else begin
      outstanding_q <= outstanding_d;
      flush_q       <= flush_d;
    end
  end

endmodule

// File: hdl/insn_tracker.sv
/*
 * Instruction tracker
 * Counts complete instructions held in the buffer from the words written
 * and the instructions issued
 */
module insn_tracker (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        branch_i,
  input  logic                        branch_addr_bit1_i,
  input  logic                        resp_keep_i,
  input  align_pkg::fetch_word_u      resp_rdata_i,
  input  logic                        issue_i,
  output logic [align_pkg::CNT_W-1:0] insn_cnt_o
);

  localparam int CW = align_pkg::CNT_W;

  logic          aligned_q;
  logic          aligned_d;
  logic          complete_q;
  logic          complete_d;
  logic [1:0]    n_incoming;
  logic          lo_ends_insn;
  logic          pop_q;
  logic [CW-1:0] cnt_q;
  logic [CW-1:0] cnt_d;

  // Lower halfword ends an instruction unless a branch skipped it
  assign lo_ends_insn = aligned_q || !complete_q;

  // Complete instructions in the incoming word
  always_comb begin
    aligned_d  = aligned_q;
    complete_d = complete_q;
    n_incoming = 2'd0;
    if (branch_i) begin
      // Unaligned target marks the lower half as skipped
      aligned_d  = !branch_addr_bit1_i;
      complete_d = branch_addr_bit1_i;
    end else if (resp_keep_i) begin
      if (aligned_q && !align_pkg::is_compressed(resp_rdata_i.half.lo)) begin
        // Full word instruction, alignment unchanged
        n_incoming = 2'd1;
      end else if (align_pkg::is_compressed(resp_rdata_i.half.hi)) begin
        // Upper half done too, next word starts aligned
        n_incoming = lo_ends_insn ? 2'd2 : 2'd1;
        aligned_d  = 1'b1;
        complete_d = 1'b1;
      end else begin
        // Upper half opens an instruction spilling into the next word
        n_incoming = lo_ends_insn ? 2'd1 : 2'd0;
        aligned_d  = 1'b0;
        complete_d = 1'b0;
      end
    end
  end

  // Pops land one cycle late to keep instr_ready_i off this path
  assign insn_cnt_o = cnt_q - CW'(pop_q);

  assign cnt_d = branch_i ? '0 : insn_cnt_o + CW'(n_incoming);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      aligned_q  <= 1'b1;
      complete_q <= 1'b0;
      pop_q      <= 1'b0;
      cnt_q      <= '0;
    end else begin
      aligned_q  <= aligned_d;
      complete_q <= complete_d;
      pop_q      <= issue_i;
      cnt_q      <= cnt_d;
    end
  end

endmodule

// File: hdl/resp_fifo.sv
/*
 * Response FIFO
 * Three word store written by kept responses, read two entries at a time
 */
module resp_fifo (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   branch_i,
  input  logic                   resp_keep_i,
  input  align_pkg::fetch_word_u resp_rdata_i,
  input  logic                   resp_err_i,
  input  logic                   issue_i,
  input  logic                   free_entry_i,
  output align_pkg::fetch_word_u head_word_o,
  output align_pkg::fetch_word_u next_word_o,
  output logic                   head_err_o,
  output logic                   next_err_o,
  output logic                   head_valid_o,
  output logic                   next_valid_o
);

  localparam int DEPTH = align_pkg::FIFO_DEPTH;
  localparam int PW    = align_pkg::PTR_W;

  align_pkg::fetch_word_u word_q [DEPTH];
  logic                   err_q  [DEPTH];
  logic [DEPTH-1:0]       valid_q;
  logic [DEPTH-1:0]       valid_d;
  logic [PW-1:0]          wptr_q;
  logic [PW-1:0]          rptr_q;
  logic [PW-1:0]          rptr_nx;
  logic                   pop;

  // Step a pointer, wrapping after the last entry
  function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] p);
    return (p == PW'(DEPTH - 1)) ? '0 : p + PW'(1);
  endfunction

  assign rptr_nx = ptr_inc(rptr_q);
  assign pop     = issue_i && free_entry_i;

  // Entry written and drained in one cycle ends up empty
  always_comb begin
    valid_d = valid_q;
    if (resp_keep_i) begin
      valid_d[wptr_q] = 1'b1;
    end
    if (pop) begin
      valid_d[rptr_q] = 1'b0;
    end
  end

  // Word storage
  always_ff @(posedge clk) begin
    if (resp_keep_i) begin
      word_q[wptr_q] <= resp_rdata_i;
      err_q[wptr_q]  <= resp_err_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
      wptr_q  <= '0;
      rptr_q  <= '0;
    end else if (branch_i) begin
      // Start over empty for the new stream
      valid_q <= '0;
      wptr_q  <= '0;
      rptr_q  <= '0;
    end else begin
      valid_q <= valid_d;
      if (resp_keep_i) begin
        wptr_q <= ptr_inc(wptr_q);
      end
      if (pop) begin
        rptr_q <= rptr_nx;
      end
    end
  end

  // Oldest word and the one after it
  assign head_word_o  = word_q[rptr_q];
  assign head_err_o   = err_q[rptr_q];
  assign head_valid_o = valid_q[rptr_q];
  assign next_word_o  = word_q[rptr_nx];
  assign next_err_o   = err_q[rptr_nx];
  assign next_valid_o = valid_q[rptr_nx];

endmodule

// File: hdl/instr_aligner.sv
/*
 * Instruction aligner
 * Builds the instruction at the current halfword address from stored
 * and incoming words, with its address and bus error
 */
module instr_aligner #(
  parameter logic [align_pkg::ADDR_W-1:0] RESET_ADDR = '0
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         branch_i,
  input  logic [align_pkg::ADDR_W-1:0] branch_addr_i,
  input  align_pkg::fetch_word_u       head_word_i,
  input  align_pkg::fetch_word_u       next_word_i,
  input  logic                         head_err_i,
  input  logic                         next_err_i,
  input  logic                         head_valid_i,
  input  logic                         next_valid_i,
  input  logic                         resp_keep_i,
  input  align_pkg::fetch_word_u       resp_rdata_i,
  input  logic                         resp_err_i,
  input  logic                         instr_ready_i,
  output logic                         instr_valid_o,
  output logic [31:0]                  instr_rdata_o,
  output logic                         instr_err_o,
  output logic [align_pkg::ADDR_W-1:0] instr_addr_o,
  output logic                         issue_o,
  output logic                         free_entry_o
);

  localparam int AW = align_pkg::ADDR_W;

  logic [AW-1:0]          addr_q;
  align_pkg::fetch_word_u first_word;
  align_pkg::fetch_word_u second_word;
  logic                   first_err;
  logic                   second_err;
  logic [15:0]            lead_half;
  logic                   is_c;
  logic                   split;
  logic [31:0]            raw;

  ////////////////////
  // Source selection
  ////////////////////

  // Incoming word stands in for an empty entry
  assign first_word  = head_valid_i ? head_word_i : resp_rdata_i;
  assign first_err   = head_valid_i ? head_err_i  : resp_err_i;
  assign second_word = next_valid_i ? next_word_i : resp_rdata_i;
  assign second_err  = next_valid_i ? next_err_i  : resp_err_i;

  // Halfword holding the opcode of the current instruction
  assign lead_half = addr_q[1] ? first_word.half.hi : first_word.half.lo;
  assign is_c      = align_pkg::is_compressed(lead_half);

  // Full size instruction starting in the upper half
  assign split = addr_q[1] && !is_c;

  always_comb begin
    if (addr_q[1]) begin
      raw = {second_word.half.lo, first_word.half.hi};
    end else begin
      raw = first_word.word;
    end
  end

  // Compressed instructions come out zero extended
  assign instr_rdata_o = is_c ? {16'h0000, raw[15:0]} : raw;

  // Both words of a split instruction can fault
  assign instr_err_o = split ? (first_err || second_err) : first_err;

  // Split needs a second word, stored or arriving
  // Nothing is issued while the address is being replaced
  assign instr_valid_o = !branch_i &&
                         (split ? (next_valid_i || (head_valid_i && resp_keep_i))
                                : (head_valid_i || resp_keep_i));

  assign issue_o = instr_valid_o && instr_ready_i;

  // Aligned compressed leaves its upper half in the entry
  assign free_entry_o = addr_q[1] || !is_c;

  ////////////////////
  // Address
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= RESET_ADDR;
    end else if (branch_i) begin
      addr_q <= {branch_addr_i[AW-1:1], 1'b0};
    end else if (issue_o) begin
      addr_q <= addr_q + (is_c ? AW'(2) : AW'(4));
    end
  end

  assign instr_addr_o = addr_q;

endmodule

// File: hdl/align_buffer_top.sv
/*
 * Instruction alignment buffer
 * Fetches words ahead and hands out 16 and 32 bit instructions in order
 */
module align_buffer_top #(
  parameter logic [align_pkg::ADDR_W-1:0] RESET_ADDR = 32'h0000_0080
) (
  input  logic                         clk,
  input  logic                         rst_n,
  // Control
  input  logic                         fetch_en_i,
  input  logic                         branch_i,
  input  logic [align_pkg::ADDR_W-1:0] branch_addr_i,
  output logic                         prefetch_busy_o,
  // Prefetcher requests
  output logic                         fetch_valid_o,
  input  logic                         fetch_ready_i,
  output logic                         fetch_branch_o,
  output logic [align_pkg::ADDR_W-1:0] fetch_branch_addr_o,
  // Prefetcher responses
  input  logic                         resp_valid_i,
  input  logic [31:0]                  resp_rdata_i,
  input  logic                         resp_err_i,
  // Instructions out
  output logic                         instr_valid_o,
  input  logic                         instr_ready_i,
  output logic [31:0]                  instr_rdata_o,
  output logic [align_pkg::ADDR_W-1:0] instr_addr_o,
  output logic                         instr_err_o
);

  align_pkg::fetch_word_u        resp_word;
  align_pkg::fetch_word_u        head_word;
  align_pkg::fetch_word_u        next_word;
  logic [align_pkg::CNT_W-1:0]   insn_cnt;
  logic                          resp_keep;
  logic                          head_err;
  logic                          next_err;
  logic                          head_valid;
  logic                          next_valid;
  logic                          issue;
  logic                          free_entry;

  assign resp_word.word = resp_rdata_i;

  // Branch target goes straight out, halfword aligned
  assign fetch_branch_o      = branch_i;
  assign fetch_branch_addr_o = {branch_addr_i[align_pkg::ADDR_W-1:1], 1'b0};

  fetch_req_ctrl u_fetch_req_ctrl (
    .clk             (clk),
    .rst_n           (rst_n),
    .fetch_en_i      (fetch_en_i),
    .branch_i        (branch_i),
    .fetch_ready_i   (fetch_ready_i),
    .resp_valid_i    (resp_valid_i),
    .insn_cnt_i      (insn_cnt),
    .fetch_valid_o   (fetch_valid_o),
    .fetch_accept_o  (),
    .resp_keep_o     (resp_keep),
    .prefetch_busy_o (prefetch_busy_o)
  );

  insn_tracker u_insn_tracker (
    .clk                (clk),
    .rst_n              (rst_n),
    .branch_i           (branch_i),
    .branch_addr_bit1_i (branch_addr_i[1]),
    .resp_keep_i        (resp_keep),
    .resp_rdata_i       (resp_word),
    .issue_i            (issue),
    .insn_cnt_o         (insn_cnt)
  );

  resp_fifo u_resp_fifo (
    .clk          (clk),
    .rst_n        (rst_n),
    .branch_i     (branch_i),
    .resp_keep_i  (resp_keep),
    .resp_rdata_i (resp_word),
    .resp_err_i   (resp_err_i),
    .issue_i      (issue),
    .free_entry_i (free_entry),
    .head_word_o  (head_word),
    .next_word_o  (next_word),
    .head_err_o   (head_err),
    .next_err_o   (next_err),
    .head_valid_o (head_valid),
    .next_valid_o (next_valid)
  );

  instr_aligner #(
    .RESET_ADDR (RESET_ADDR)
  ) u_instr_aligner (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .head_word_i   (head_word),
    .next_word_i   (next_word),
    .head_err_i    (head_err),
    .next_err_i    (next_err),
    .head_valid_i  (head_valid),
    .next_valid_i  (next_valid),
    .resp_keep_i   (resp_keep),
    .resp_rdata_i  (resp_word),
    .resp_err_i    (resp_err_i),
    .instr_ready_i (instr_ready_i),
    .instr_valid_o (instr_valid_o),
    .instr_rdata_o (instr_rdata_o),
    .instr_err_o   (instr_err_o),
    .instr_addr_o  (instr_addr_o),
    .issue_o       (issue),
    .free_entry_o  (free_entry)
  );

endmodule

// File: verif/align_buffer_tb.sv
/*
 * Alignment buffer testbench
 * Prefetcher and memory model, a table of branch targets and a
 * reference walk over the memory by halfwords
 */
module align_buffer_tb;

  localparam logic [31:0] RESET_ADDR = 32'h0000_0080;
  localparam int          NUM_ROWS   = 7;
  localparam int          TIMEOUT    = 200;
  localparam logic [7:0]  LFSR_SEED  = 8'd81;

  // Branch target, instructions to collect, ready mode, faulting words
  typedef struct packed {
    logic [31:0] addr;
    logic [7:0]  count;
    logic [1:0]  mode;
    logic [63:0] err;
  } row_t;

  // Ready mode 0 always, 1 random, 2 stalled for the first cycles
  localparam row_t ROWS [NUM_ROWS] = '{
    '{32'h0000_0000, 8'd8,  2'd0, 64'h0},
    '{32'h0000_0040, 8'd20, 2'd0, 64'h0},
    '{32'h0000_0062, 8'd12, 2'd0, 64'h0},
    '{32'h0000_0050, 8'd6,  2'd2, 64'h0},
    '{32'h0000_0046, 8'd15, 2'd0, 64'h0000_0000_000C_0000},
    '{32'h0000_0044, 8'd30, 2'd1, 64'h0000_0000_8210_0000},
    '{32'h0000_000B, 8'd10, 2'd1, 64'h0}
  };

  logic        clk;
  logic        rst_n;
  logic        fetch_en_i;
  logic        branch_i;
  logic [31:0] branch_addr_i;
  logic        prefetch_busy_o;
  logic        fetch_valid_o;
  logic        fetch_ready_i;
  logic        fetch_branch_o;
  logic [31:0] fetch_branch_addr_o;
  logic        resp_valid_i;
  logic [31:0] resp_rdata_i;
  logic        resp_err_i;
  logic        instr_valid_o;
  logic        instr_ready_i;
  logic [31:0] instr_rdata_o;
  logic [31:0] instr_addr_o;
  logic        instr_err_o;

  // Memory model and the error bit of each word
  logic [31:0]  mem [64];
  logic [63:0]  err_mask;
  // Requests in flight, word address and cycle of the response
  logic [31:0]  pend_addr [$];
  int unsigned  pend_cyc [$];
  int unsigned  cyc = 0;
  logic [7:0]   ready_lfsr;
  int           errors = 0;
  int           checks = 0;
  int           tests = 0;
  bit           timed_out = 1'b0;

  align_buffer_top #(
    .RESET_ADDR (RESET_ADDR)
  ) UUT (
    .clk                 (clk),
    .rst_n               (rst_n),
    .fetch_en_i          (fetch_en_i),
    .branch_i            (branch_i),
    .branch_addr_i       (branch_addr_i),
    .prefetch_busy_o     (prefetch_busy_o),
    .fetch_valid_o       (fetch_valid_o),
    .fetch_ready_i       (fetch_ready_i),
    .fetch_branch_o      (fetch_branch_o),
    .fetch_branch_addr_o (fetch_branch_addr_o),
    .resp_valid_i        (resp_valid_i),
    .resp_rdata_i        (resp_rdata_i),
    .resp_err_i          (resp_err_i),
    .instr_valid_o       (instr_valid_o),
    .instr_ready_i       (instr_ready_i),
    .instr_rdata_o       (instr_rdata_o),
    .instr_addr_o        (instr_addr_o),
    .instr_err_o         (instr_err_o)
  );

  ////////////////////
  // Helpers
  ////////////////////

  // Galois LFSR, taps 0xB8
  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
  endfunction

  // Halfword contents from its index, opcode bits mixed by address
  function automatic logic [15:0] fill_half(input logic [15:0] h);
    logic [1:0] op;
    op = {h[1] ^ h[3], h[0] ^ h[2]};
    // First 16 words hold full size instructions only
    if (h < 16'd32 && !h[0]) begin
      op = 2'b11;
    end
    return {h[13:0], op};
  endfunction

  function automatic logic [15:0] half_at(input logic [31:0] a);
    logic [31:0] w;
    w = mem[a[7:2]];
    return a[1] ? w[31:16] : w[15:0];
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // One branch cycle, counts stale requests still to be answered
  task automatic start_branch(input logic [31:0] target, output int in_flight);
    @(posedge clk);
    #1;
    fetch_en_i    = 1'b1;
    branch_i      = 1'b1;
    branch_addr_i = target;
    instr_ready_i = 1'b0;
    #1;
    in_flight = pend_addr.size();
    @(negedge clk);
    check_value("instr_valid_o", 32'(instr_valid_o), 32'd0);
    // Restart request goes to the target with bit 0 dropped
    check_value("fetch_branch_o", 32'(fetch_branch_o), 32'd1);
    check_value("fetch_branch_addr_o", fetch_branch_addr_o, target & ~32'd1);
  endtask

  // Take n instructions and compare each with the reference walk
  task automatic collect(input logic [31:0] start, input int n, input int mode);
    logic [31:0] pc;
    logic [15:0] lo;
    logic [15:0] hi;
    logic [31:0] exp_data;
    logic        exp_err;
    int          got;
    int          idle;
    int          cycles;
    pc     = {start[31:1], 1'b0};
    got    = 0;
    idle   = 0;
    cycles = 0;
    while (got < n && !timed_out) begin
      @(posedge clk);
      #1;
      branch_i = 1'b0;
      case (mode)
        1: begin
          ready_lfsr    = lfsr_next(ready_lfsr);
          instr_ready_i = ready_lfsr[0];
        end
        2:       instr_ready_i = (cycles >= 8);
        default: instr_ready_i = 1'b1;
      endcase
      cycles++;
      @(negedge clk);
      if (instr_valid_o && instr_ready_i) begin
        lo = half_at(pc);
        // Opcode bits 11 mean a full size instruction
        if (lo[1:0] != 2'b11) begin
          exp_data = {16'h0000, lo};
          exp_err  = err_mask[pc[7:2]];
        end else begin
          hi       = half_at(pc + 32'd2);
          exp_data = {hi, lo};
          exp_err  = err_mask[pc[7:2]] | err_mask[pc[7:2] + 6'd1 - 6'(!pc[1])];
        end
        check_value("instr_addr_o", instr_addr_o, pc);
        check_value("instr_rdata_o", instr_rdata_o, exp_data);
        check_value("instr_err_o", 32'(instr_err_o), 32'(exp_err));
        pc   = pc + ((lo[1:0] != 2'b11) ? 32'd2 : 32'd4);
        got  = got + 1;
        idle = 0;
      end else begin
        idle = idle + 1;
        if (idle >= TIMEOUT) begin
          $display("Timeout: no instruction for %0d cycles, waiting at %h", TIMEOUT, pc);
          timed_out = 1'b1;
        end
      end
    end
  endtask

  ////////////////////
  // Clock and prefetcher
  ////////////////////

  initial begin : clock_gen
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  initial begin : prefetcher
    logic [31:0] next_addr;
    logic [31:0] a;
    int unsigned due;
    logic [7:0]  delay_lfsr;
    delay_lfsr    = LFSR_SEED;
    next_addr     = {RESET_ADDR[31:2], 2'b00};
    fetch_ready_i = 1'b1;
    resp_valid_i  = 1'b0;
    resp_rdata_i  = '0;
    resp_err_i    = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      // Oldest request answered once its delay has run out
      if (pend_addr.size() > 0 && pend_cyc[0] <= cyc) begin
        a = pend_addr.pop_front();
        void'(pend_cyc.pop_front());
        resp_valid_i = 1'b1;
        resp_rdata_i = mem[a[7:2]];
        resp_err_i   = err_mask[a[7:2]];
      end else begin
        resp_valid_i = 1'b0;
        resp_rdata_i = '0;
        resp_err_i   = 1'b0;
      end
      @(negedge clk);
      // Busy while a request waits or any response is still owed
      check_value("prefetch_busy_o", 32'(prefetch_busy_o),
                  32'((pend_addr.size() != 0) || resp_valid_i || fetch_valid_o));
      // Branch restarts the word stream even without a request
      if (fetch_branch_o) begin
        next_addr = {fetch_branch_addr_o[31:2], 2'b00};
      end
      if (fetch_valid_o && fetch_ready_i) begin
        // Two bits taken, delay of 1 to 3 cycles
        delay_lfsr = lfsr_next(delay_lfsr);
        due        = cyc + 1 + 32'(delay_lfsr[0]);
        delay_lfsr = lfsr_next(delay_lfsr);
        due        = due + 32'(delay_lfsr[0]);
        // Keep responses in order, one per cycle
        if (pend_cyc.size() > 0 && due <= pend_cyc[$]) begin
          due = pend_cyc[$] + 1;
        end
        pend_addr.push_back(next_addr);
        pend_cyc.push_back(due);
        next_addr = next_addr + 32'd4;
        assert (pend_addr.size() <= align_pkg::MAX_OUTSTANDING) else begin
          $display("At %0t more than %0d fetch requests are outstanding",
                   $time, align_pkg::MAX_OUTSTANDING);
          errors++;
        end
      end
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin : stimulus
    int err_before;
    int in_flight;
    rst_n         = 1'b0;
    fetch_en_i    = 1'b0;
    branch_i      = 1'b0;
    branch_addr_i = '0;
    instr_ready_i = 1'b0;
    ready_lfsr    = LFSR_SEED;
    err_mask      = '0;
    for (int i = 0; i < 64; i++) begin
      mem[6'(i)] = {fill_half(16'(2 * i + 1)), fill_half(16'(2 * i))};
    end
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Fetch disabled, nothing moves
    err_before = errors;
    for (int c = 0; c < 10; c++) begin
      @(negedge clk);
      check_value("instr_valid_o", 32'(instr_valid_o), 32'd0);
      check_value("fetch_valid_o", 32'(fetch_valid_o), 32'd0);
      check_value("prefetch_busy_o", 32'(prefetch_busy_o), 32'd0);
      check_value("instr_addr_o", instr_addr_o, RESET_ADDR);
    end
    tests = 1;
    $display("Test 0 idle after reset: %0d errors", errors - err_before);

    for (int r = 0; r < NUM_ROWS && !timed_out; r++) begin
      err_before = errors;
      err_mask   = ROWS[3'(r)].err;
      start_branch(ROWS[3'(r)].addr, in_flight);
      collect(ROWS[3'(r)].addr, int'(ROWS[3'(r)].count), int'(ROWS[3'(r)].mode));
      tests++;
      $display("Test %0d branch to %h: %0d instructions, %0d stale requests, %0d errors",
               r + 1, ROWS[3'(r)].addr, ROWS[3'(r)].count, in_flight, errors - err_before);
    end

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (!timed_out && errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: sim.f
hdl/align_pkg.sv
hdl/fetch_req_ctrl.sv
hdl/insn_tracker.sv
hdl/resp_fifo.sv
hdl/instr_aligner.sv
hdl/align_buffer_top.sv
verif/align_buffer_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing -j 0
TOP      := align_buffer_tb
FILELIST := sim.f
BUILD    := obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee /dev/stderr | grep -qx "all tests passed"

clean:
	rm -rf $(BUILD)
